// ==== src.f ====
rtl/xip_pkg.sv
rtl/xip_prescaler.sv
rtl/xip_cfg_regs.sv
rtl/xip_phy.sv
rtl/xip_ctrl.sv
rtl/xip_top.sv
verif/xip_clk_gen.sv
verif/xip_flash_model.sv
verif/xip_checker.sv
verif/xip_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = xip_tb
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/xip_tb.sv ====
// xip read path testbench
// register access, single and sequential reads, spi modes, disable abort

`timescale 1ns/1ps

module xip_tb import xip_pkg::*;;

    // slowest read, 2 ticks per bit plus close and sync, 256 clocks a tick
    localparam int TICKS_PER_READ = 2 * (64 + 8) + 8;
    localparam int WD_CYCLES      = 40 * TICKS_PER_READ * 256 + 2000;
    localparam int CLK_NS         = 100;

    logic                  clk;
    logic                  arst_n;
    logic                  cfg_we;
    logic [1:0]            cfg_addr;
    logic [31:0]           cfg_wdata;
    logic [31:0]           cfg_rdata;
    logic                  rd_req;
    logic [XIP_ADDR_W-1:0] rd_addr;
    logic                  rd_busy;
    logic                  rd_ack;
    logic [XIP_DATA_W-1:0] rd_data;
    logic                  spi_csn;
    logic                  spi_clk;
    logic                  spi_mosi;
    logic                  spi_miso;
    int                    reg_errs;
    int                    timeouts;
    logic [XIP_ADDR_W-1:0] base;

    xip_clk_gen xip_clk_gen_inst (.clk_o(clk));

    xip_top xip_top_inst (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata),
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .rd_busy_o   (rd_busy),
        .rd_ack_o    (rd_ack),
        .rd_data_o   (rd_data),
        .spi_csn_o   (spi_csn),
        .spi_clk_o   (spi_clk),
        .spi_dat_o   (spi_mosi),
        .spi_dat_i   (spi_miso)
    );

    xip_flash_model xip_flash_model_inst (
        .spi_csn_i  (spi_csn),
        .spi_clk_i  (spi_clk),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso)
    );

    // ------------------------------
    // bus tasks
    // ------------------------------
    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic cfg_expect(input logic [1:0] addr, input logic [31:0] exp);
        @(negedge clk);
        cfg_addr = addr;
        #10;                                           // comb read settles
        assert (cfg_rdata == exp)
            else begin
                reg_errs++;
                $error("mismatch cfg_rdata_o reg %0d exp %h got %h", addr, exp, cfg_rdata);
            end
    endtask

    function automatic logic [31:0] ctrl_word(input logic en, input logic cpol,
                                              input logic cpha, input logic [2:0] div);
        logic [31:0] w;
        w = '0;
        w[XIP_CTRL_EN_BIT]              = en;
        w[XIP_CTRL_CPOL_BIT]            = cpol;
        w[XIP_CTRL_CPHA_BIT]            = cpha;
        w[XIP_CTRL_DIV_LSB +: XIP_DIV_W] = div;
        return w;
    endfunction

    // disable first so the open stream closes, then enable in the new mode
    task automatic set_mode(input logic cpol, input logic cpha, input logic [2:0] div);
        cfg_write(XIP_REG_CTRL, ctrl_word(1'b0, cpol, cpha, div));
        repeat (4) @(negedge clk);
        cfg_write(XIP_REG_CTRL, ctrl_word(1'b1, cpol, cpha, div));
    endtask

    task automatic read_word(input logic [XIP_ADDR_W-1:0] addr);
        @(negedge clk);
        while (rd_busy) @(negedge clk);
        rd_req  = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_req  = 1'b0;
        while (!rd_ack) @(negedge clk);                // watchdog covers a lost ack
    endtask

    function automatic logic [XIP_ADDR_W-1:0] random_addr();
        return XIP_ADDR_W'($urandom & 32'h00FF_FFFC);
    endfunction

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        #(WD_CYCLES * CLK_NS);
        timeouts = 1;
        $display("timeout, reads did not complete in the expected time");
        $display("assertion failures %0d, timeouts %0d",
                 reg_errs + xip_top_inst.xip_checker_inst.fail_cnt, timeouts);
        $display("test failed");
        $finish;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        void'($urandom(89));
        reg_errs  = 0;
        timeouts  = 0;
        arst_n    = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rd_req    = 1'b0;
        rd_addr   = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // register access, reset values first
        cfg_expect(XIP_REG_CTRL, 32'h0);
        cfg_expect(XIP_REG_CMD, 32'h3);
        cfg_write(XIP_REG_CTRL, 32'hFFFF_FFFF);
        cfg_expect(XIP_REG_CTRL, 32'h3F);
        cfg_write(XIP_REG_CTRL, 32'h0);
        cfg_write(XIP_REG_CMD, 32'h1234_5678);
        cfg_expect(XIP_REG_CMD, 32'h78);
        cfg_write(XIP_REG_CMD, 32'h3);
        cfg_expect(2'd2, 32'h0);
        cfg_expect(2'd3, 32'h0);

        // single reads in mode 0 at two dividers
        set_mode(1'b0, 1'b0, 3'd0);
        repeat (6) read_word(random_addr());
        set_mode(1'b0, 1'b0, 3'd1);
        repeat (4) read_word(random_addr());

        // sequential burst, then a jump
        base = random_addr();
        read_word(base);
        read_word(base + 24'd4);
        read_word(base + 24'd8);
        read_word(base + 24'h100);

        // mode 3 with a short burst
        set_mode(1'b1, 1'b1, 3'd0);
        base = random_addr();
        read_word(base);
        read_word(base + 24'd4);
        read_word(random_addr());

        // modes 1 and 2, idle clock level only
        set_mode(1'b0, 1'b1, 3'd0);
        repeat (2) read_word(random_addr());
        set_mode(1'b1, 1'b0, 3'd0);
        repeat (2) read_word(random_addr());

        // abort a read by clearing enable
        set_mode(1'b0, 1'b0, 3'd2);
        @(negedge clk);
        rd_req  = 1'b1;
        rd_addr = random_addr();
        @(negedge clk);
        rd_req  = 1'b0;
        while (spi_csn) @(negedge clk);
        repeat (40) @(negedge clk);
        cfg_write(XIP_REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 3'd2));
        repeat (10) @(negedge clk);

        // recovery after abort
        set_mode(1'b0, 1'b0, 3'd0);
        read_word(random_addr());
        repeat (20) @(negedge clk);

        $display("assertion failures %0d, timeouts %0d",
                 reg_errs + xip_top_inst.xip_checker_inst.fail_cnt, timeouts);
        if ((reg_errs + xip_top_inst.xip_checker_inst.fail_cnt) == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verif/xip_checker.sv ====
// bound checks on the xip top level
// bus acknowledge and read data, sequential chip select, idle clock, abort

`timescale 1ns/1ps

module xip_checker import xip_pkg::*; (
    input logic                  clk_i,
    input logic                  arst_n_i,
    input logic                  cfg_en_i,
    input logic                  cfg_cpol_i,
    input logic                  cfg_cpha_i,
    input logic                  rd_req_i,
    input logic [XIP_ADDR_W-1:0] rd_addr_i,
    input logic                  rd_busy_i,
    input logic                  rd_ack_i,
    input logic [XIP_DATA_W-1:0] rd_data_i,
    input logic                  spi_csn_i,
    input logic                  spi_clk_i
);

    int fail_cnt = 0;                                  // read by the testbench

    logic                  pending_q;                  // request waiting for ack
    logic                  open_q;                     // flash still streaming
    logic                  seq_q;                      // current request is sequential
    logic                  csn_rose_q;                 // csn seen high since request
    logic                  en_d_q;
    logic                  cpol_d_q;
    logic [3:0]            off_cnt_q;                  // disabled cycles with csn low
    logic [XIP_ADDR_W-1:0] req_addr_q;
    logic [XIP_ADDR_W-1:0] next_addr_q;

    // expected word, flash byte rule, first byte on top
    function automatic logic [XIP_DATA_W-1:0] flash_word(input logic [XIP_ADDR_W-1:0] a);
        logic [XIP_DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            w = {w[23:0], (a[7:0] + 8'(i)) ^ 8'hA5};
        end
        return w;
    endfunction

    // ------------------------------
    // request tracking
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q   <= 1'b0;
            open_q      <= 1'b0;
            seq_q       <= 1'b0;
            csn_rose_q  <= 1'b0;
            en_d_q      <= 1'b0;
            cpol_d_q    <= 1'b0;
            off_cnt_q   <= '0;
            req_addr_q  <= '0;
            next_addr_q <= '0;
        end else begin
            en_d_q     <= cfg_en_i;
            cpol_d_q   <= cfg_cpol_i;
            off_cnt_q  <= (!cfg_en_i && !spi_csn_i) ? off_cnt_q + 1'b1 : '0;
            csn_rose_q <= csn_rose_q | spi_csn_i;
            if (spi_csn_i) begin
                open_q <= 1'b0;                        // stream broken
            end
            if (rd_ack_i || !cfg_en_i) begin
                pending_q <= 1'b0;
                seq_q     <= 1'b0;
            end
            if (rd_ack_i) begin
                open_q      <= 1'b1;
                next_addr_q <= req_addr_q + 24'd4;
            end
            if (rd_req_i && !rd_busy_i && cfg_en_i) begin
                pending_q  <= 1'b1;
                req_addr_q <= rd_addr_i;
                seq_q      <= open_q && !spi_csn_i && (rd_addr_i == next_addr_q);
                csn_rose_q <= spi_csn_i;
            end
        end
    end

    // ------------------------------
    // assertions
    // ------------------------------
    a_ack_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rd_ack_i |-> pending_q)
        else begin
            fail_cnt++;
            $error("acknowledge seen without a pending read request");
        end

    // data only defined in modes 0 and 3
    a_rd_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack_i && (cfg_cpol_i == cfg_cpha_i)) |-> (rd_data_i == flash_word(req_addr_q)))
        else begin
            fail_cnt++;
            $error("mismatch rd_data_o addr %h exp %h got %h",
                   req_addr_q, flash_word(req_addr_q), rd_data_i);
        end

    a_seq_csn: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (pending_q && seq_q) |-> !spi_csn_i)
        else begin
            fail_cnt++;
            $error("chip select went high during a sequential read");
        end

    a_new_cmd_csn: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack_i && !seq_q) |-> csn_rose_q)
        else begin
            fail_cnt++;
            $error("non-sequential read finished without chip select going high");
        end

    a_idle_clk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (spi_csn_i && (cpol_d_q == cfg_cpol_i)) |-> (spi_clk_i == cfg_cpol_i))
        else begin
            fail_cnt++;
            $error("mismatch spi_clk_o idle level exp %h got %h", cfg_cpol_i, spi_clk_i);
        end

    a_abort_csn: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        off_cnt_q <= 4'd3)
        else begin
            fail_cnt++;
            $error("chip select still low several cycles after disable");
        end

    a_abort_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (!cfg_en_i && !en_d_q) |-> !rd_busy_i)
        else begin
            fail_cnt++;
            $error("read busy still high after disable");
        end

endmodule

bind xip_top xip_checker xip_checker_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cfg_en_i   (cfg_en),
    .cfg_cpol_i (cfg_cpol),
    .cfg_cpha_i (cfg_cpha),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_busy_i  (rd_busy_o),
    .rd_ack_i   (rd_ack_o),
    .rd_data_i  (rd_data_o),
    .spi_csn_i  (spi_csn_o),
    .spi_clk_i  (spi_clk_o)
);

// ==== verif/xip_flash_model.sv ====
// behavioural spi flash, READ command only
// byte at address a is a[7:0] ^ 0xA5, modes 0 and 3, streams while csn low

`timescale 1ns/1ps

module xip_flash_model (
    input  logic spi_csn_i,
    input  logic spi_clk_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);

    localparam logic [7:0] READ_OPC = 8'h03;           // plain READ of the flash

    int unsigned edges;                                // rising edges since select
    int unsigned data_bit;                             // bit index in data phase
    logic [31:0] cmd_q;                                // opcode and address
    logic [23:0] byte_addr;
    logic [7:0]  byte_val;

    initial begin
        edges      = 0;
        cmd_q      = '0;
        spi_miso_o = 1'b0;
    end

    // deselect ends the stream
    always @(posedge spi_csn_i) begin
        edges      = 0;
        spi_miso_o <= 1'b0;
    end

    // command phase sampled on rising edge
    always @(posedge spi_clk_i) begin
        if (!spi_csn_i) begin
            if (edges < 32) begin
                cmd_q = {cmd_q[30:0], spi_mosi_i};
            end
            edges = edges + 1;
        end
    end

    // data launched on falling edge, ready for the next rise
    always @(negedge spi_clk_i) begin
        if (!spi_csn_i && edges >= 32) begin
            data_bit   = edges - 32;
            byte_addr  = cmd_q[23:0] + 24'(data_bit / 8);
            byte_val   = byte_addr[7:0] ^ 8'hA5;
            if (cmd_q[31:24] == READ_OPC) begin
                spi_miso_o <= byte_val[7 - (data_bit % 8)];
            end else begin
                spi_miso_o <= 1'b0;                    // unknown command, no answer
            end
        end
    end

endmodule

// ==== verif/xip_clk_gen.sv ====
// testbench clock source
// free-running clock, 100 ns period

`timescale 1ns/1ps

module xip_clk_gen (
    output logic clk_o
);

    localparam int HALF_NS = 50;                       // half of 100 ns

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

endmodule

// ==== rtl/xip_top.sv ====
// xip read path top
// config registers, prescaler, read controller and spi engine

`timescale 1ns/1ps

module xip_top import xip_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // config port
    input  logic                  cfg_we_i,
    input  logic [1:0]            cfg_addr_i,
    input  logic [31:0]           cfg_wdata_i,
    output logic [31:0]           cfg_rdata_o,
    // bus port
    input  logic                  rd_req_i,
    input  logic [XIP_ADDR_W-1:0] rd_addr_i,
    output logic                  rd_busy_o,
    output logic                  rd_ack_o,
    output logic [XIP_DATA_W-1:0] rd_data_o,
    // flash pins
    output logic                  spi_csn_o,
    output logic                  spi_clk_o,
    output logic                  spi_dat_o,
    input  logic                  spi_dat_i
);

    logic                    cfg_en;
    logic                    cfg_cpol;
    logic                    cfg_cpha;
    logic [XIP_DIV_W-1:0]    cfg_div;
    logic [XIP_OPC_W-1:0]    cfg_opcode;
    logic                    spi_clk_en;
    logic                    op_start;
    logic                    op_final;
    logic                    op_busy;
    logic [XIP_NBYTES_W-1:0] op_nbytes;
    logic [XIP_SREG_W-1:0]   op_wdata;
    logic [XIP_DATA_W-1:0]   op_rdata;

    xip_cfg_regs xip_cfg_regs_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rdata_o  (cfg_rdata_o),
        .cfg_en_o     (cfg_en),
        .cfg_cpol_o   (cfg_cpol),
        .cfg_cpha_o   (cfg_cpha),
        .cfg_div_o    (cfg_div),
        .cfg_opcode_o (cfg_opcode)
    );

    xip_prescaler xip_prescaler_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cfg_en_i     (cfg_en),
        .cfg_div_i    (cfg_div),
        .spi_clk_en_o (spi_clk_en)
    );

    xip_ctrl xip_ctrl_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cfg_en_i     (cfg_en),
        .cfg_opcode_i (cfg_opcode),
        .rd_req_i     (rd_req_i),
        .rd_addr_i    (rd_addr_i),
        .op_busy_i    (op_busy),
        .op_rdata_i   (op_rdata),
        .rd_busy_o    (rd_busy_o),
        .rd_ack_o     (rd_ack_o),
        .rd_data_o    (rd_data_o),
        .op_start_o   (op_start),
        .op_final_o   (op_final),
        .op_nbytes_o  (op_nbytes),
        .op_wdata_o   (op_wdata)
    );

    xip_phy xip_phy_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .spi_clk_en_i (spi_clk_en),
        .cf_enable_i  (cfg_en),
        .cf_cpha_i    (cfg_cpha),
        .cf_cpol_i    (cfg_cpol),
        .op_start_i   (op_start),
        .op_final_i   (op_final),
        .op_nbytes_i  (op_nbytes),
        .op_wdata_i   (op_wdata),
        .spi_dat_i    (spi_dat_i),
        .op_busy_o    (op_busy),
        .op_rdata_o   (op_rdata),
        .spi_csn_o    (spi_csn_o),
        .spi_clk_o    (spi_clk_o),
        .spi_dat_o    (spi_dat_o)
    );

endmodule

// ==== rtl/xip_ctrl.sv ====
// xip read controller
// bus word reads to flash READ commands, resumes open transfer on sequential address

`timescale 1ns/1ps

module xip_ctrl import xip_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    cfg_en_i,
    input  logic [XIP_OPC_W-1:0]    cfg_opcode_i,
    input  logic                    rd_req_i,      // one-cycle strobe
    input  logic [XIP_ADDR_W-1:0]   rd_addr_i,     // word aligned
    input  logic                    op_busy_i,
    input  logic [XIP_DATA_W-1:0]   op_rdata_i,
    output logic                    rd_busy_o,
    output logic                    rd_ack_o,      // one-cycle, data valid with it
    output logic [XIP_DATA_W-1:0]   rd_data_o,
    output logic                    op_start_o,
    output logic                    op_final_o,
    output logic [XIP_NBYTES_W-1:0] op_nbytes_o,
    output logic [XIP_SREG_W-1:0]   op_wdata_o
);

    typedef enum logic [1:0] {
        ST_IDLE,    // wait for a bus request
        ST_CLOSE,   // final pulse out, engine dropping csn
        ST_RUN,     // start pulse out, engine not yet busy
        ST_BUSY     // engine shifting
    } ctrl_state_t;

    ctrl_state_t           state_q;
    logic                  open_q;                 // engine parked in wait, csn low
    logic [XIP_ADDR_W-1:0] addr_q;                 // address of current request
    logic [XIP_ADDR_W-1:0] next_addr_q;            // word the open transfer streams next

    // ------------------------------
    // request sequencing
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ST_IDLE;
            open_q      <= 1'b0;
            rd_busy_o   <= 1'b0;
            rd_ack_o    <= 1'b0;
            op_start_o  <= 1'b0;
            op_final_o  <= 1'b0;
            addr_q      <= '0;
            next_addr_q <= '0;
        end else begin
            rd_ack_o   <= 1'b0;                        // pulses by default
            op_start_o <= 1'b0;
            op_final_o <= 1'b0;
            if (!cfg_en_i) begin                       // engine clears too
                state_q   <= ST_IDLE;
                open_q    <= 1'b0;
                rd_busy_o <= 1'b0;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        if (rd_req_i) begin
                            rd_busy_o <= 1'b1;
                            addr_q    <= rd_addr_i;
                            if (open_q && (rd_addr_i == next_addr_q)) begin
                                op_start_o <= 1'b1;    // resume 32 bits
                                state_q    <= ST_RUN;
                            end else if (open_q) begin
                                op_final_o <= 1'b1;    // end stale stream first
                                open_q     <= 1'b0;
                                state_q    <= ST_CLOSE;
                            end else begin
                                op_start_o <= 1'b1;    // fresh command
                                state_q    <= ST_RUN;
                            end
                        end
                    end
                    ST_CLOSE: begin                    // engine idle from here on
                        op_start_o <= 1'b1;
                        state_q    <= ST_RUN;
                    end
                    ST_RUN: state_q <= ST_BUSY;        // engine picks up start this edge
                    ST_BUSY: begin
                        if (!op_busy_i) begin          // word complete, engine in wait
                            rd_ack_o    <= 1'b1;
                            rd_busy_o   <= 1'b0;
                            open_q      <= 1'b1;
                            next_addr_q <= addr_q + XIP_ADDR_W'(4);
                            state_q     <= ST_IDLE;
                        end
                    end
                    default: state_q <= ST_IDLE;
                endcase
            end
        end
    end

    // read word, loaded with the ack
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_BUSY) && !op_busy_i) begin
            rd_data_o <= op_rdata_i;
        end
    end

    // opcode, address, then zeros while data shifts in
    assign op_wdata_o  = {cfg_opcode_i, addr_q, {(XIP_SREG_W-XIP_OPC_W-XIP_ADDR_W){1'b0}}};
    assign op_nbytes_o = XIP_CMD_NBYTES;               // only used on a fresh command

endmodule

// ==== rtl/xip_phy.sv ====
// xip spi serial engine
// msb-first shifter up to 72 bits, all four clock modes,
// chip select held low between transfers for sequential resume

`timescale 1ns/1ps

module xip_phy import xip_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    spi_clk_en_i,  // prescaled tick
    input  logic                    cf_enable_i,   // sync clear when low
    input  logic                    cf_cpha_i,
    input  logic                    cf_cpol_i,     // idle clock level
    input  logic                    op_start_i,    // new transfer, or resume from wait
    input  logic                    op_final_i,    // release flash from wait
    input  logic [XIP_NBYTES_W-1:0] op_nbytes_i,   // bytes on a new transfer
    input  logic [XIP_SREG_W-1:0]   op_wdata_i,    // left aligned tx data
    input  logic                    spi_dat_i,
    output logic                    op_busy_o,
    output logic [XIP_DATA_W-1:0]   op_rdata_o,    // last 32 bits shifted in
    output logic                    spi_csn_o,
    output logic                    spi_clk_o,
    output logic                    spi_dat_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT, S_START, S_SYNC, S_RTX_A, S_RTX_B, S_DONE
    } phy_state_t;

    phy_state_t                  state_q;
    logic [XIP_SREG_W-1:0]       sreg_q;           // tx out on top, rx in at bottom
    logic [XIP_NBYTES_W+2:0]     bitcnt_q;         // bits left, up to 72
    logic                        di_sync_q;        // sampled input bit

    // ------------------------------
    // serial FSM
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= S_IDLE;
            spi_csn_o <= 1'b1;
            spi_clk_o <= 1'b0;
            sreg_q    <= '0;
            bitcnt_q  <= '0;
            di_sync_q <= 1'b0;
        end else if (!cf_enable_i) begin               // abort, back to idle pins
            state_q   <= S_IDLE;
            spi_csn_o <= 1'b1;
            spi_clk_o <= cf_cpol_i;
            sreg_q    <= '0;
            bitcnt_q  <= '0;
            di_sync_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    spi_csn_o <= 1'b1;                 // flash deselected
                    spi_clk_o <= cf_cpol_i;
                    bitcnt_q  <= {op_nbytes_i, 3'b000};
                    if (op_start_i) begin
                        state_q <= S_START;
                    end
                end
                S_START: begin
                    sreg_q <= op_wdata_i;              // csn untouched here
                    if (spi_clk_en_i) begin
                        state_q <= S_SYNC;
                    end
                end
                S_WAIT: begin
                    spi_csn_o <= 1'b0;                 // keep flash streaming
                    bitcnt_q  <= ($bits(bitcnt_q))'(XIP_RESUME_BITS);
                    if (op_final_i) begin
                        state_q <= S_IDLE;
                    end else if (op_start_i) begin     // resume, no new command
                        state_q <= S_SYNC;
                    end
                end
                S_SYNC: begin
                    spi_csn_o <= 1'b0;
                    if (spi_clk_en_i) begin
                        if (cf_cpha_i) begin
                            spi_clk_o <= ~cf_cpol_i;   // leading edge for cpha 1
                        end
                        state_q <= S_RTX_A;
                    end
                end
                S_RTX_A: begin
                    if (spi_clk_en_i) begin
                        spi_clk_o <= ~(cf_cpha_i ^ cf_cpol_i);  // sample edge
                        di_sync_q <= spi_dat_i;
                        bitcnt_q  <= bitcnt_q - 1'b1;
                        state_q   <= S_RTX_B;
                    end
                end
                S_RTX_B: begin
                    if (spi_clk_en_i) begin
                        sreg_q <= {sreg_q[XIP_SREG_W-2:0], di_sync_q};
                        if (bitcnt_q == '0) begin      // last bit done
                            spi_clk_o <= cf_cpol_i;
                            state_q   <= S_DONE;
                        end else begin
                            spi_clk_o <= cf_cpha_i ^ cf_cpol_i;
                            state_q   <= S_RTX_A;
                        end
                    end
                end
                S_DONE: begin
                    if (spi_clk_en_i) begin            // csn hold time
                        state_q <= S_WAIT;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // busy everywhere but idle and wait
    assign op_busy_o  = (state_q != S_IDLE) && (state_q != S_WAIT);
    assign spi_dat_o  = sreg_q[XIP_SREG_W-1];         // msb first
    assign op_rdata_o = sreg_q[XIP_DATA_W-1:0];

endmodule

// ==== rtl/xip_cfg_regs.sv ====
// xip configuration registers
// control (enable, cpol, cpha, divider) and command (read opcode)

`timescale 1ns/1ps

module xip_cfg_regs import xip_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 cfg_we_i,        // write strobe
    input  logic [1:0]           cfg_addr_i,      // register select
    input  logic [31:0]          cfg_wdata_i,
    output logic [31:0]          cfg_rdata_o,     // comb read of addressed reg
    output logic                 cfg_en_o,
    output logic                 cfg_cpol_o,
    output logic                 cfg_cpha_o,
    output logic [XIP_DIV_W-1:0] cfg_div_o,
    output logic [XIP_OPC_W-1:0] cfg_opcode_o
);

    logic                 en_q;
    logic                 cpol_q;
    logic                 cpha_q;
    logic [XIP_DIV_W-1:0] div_q;
    logic [XIP_OPC_W-1:0] opcode_q;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q     <= 1'b0;                          // disabled out of reset
            cpol_q   <= 1'b0;                          // mode 0
            cpha_q   <= 1'b0;
            div_q    <= '0;                            // fastest spi clock
            opcode_q <= XIP_OPC_READ_DEF;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == XIP_REG_CTRL) begin
                en_q   <= cfg_wdata_i[XIP_CTRL_EN_BIT];
                cpol_q <= cfg_wdata_i[XIP_CTRL_CPOL_BIT];
                cpha_q <= cfg_wdata_i[XIP_CTRL_CPHA_BIT];
                div_q  <= cfg_wdata_i[XIP_CTRL_DIV_LSB +: XIP_DIV_W];
            end else if (cfg_addr_i == XIP_REG_CMD) begin
                opcode_q <= cfg_wdata_i[XIP_OPC_W-1:0];
            end
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    always_comb begin
        cfg_rdata_o = '0;                              // unused bits and addresses read zero
        case (cfg_addr_i)
            XIP_REG_CTRL: begin
                cfg_rdata_o[XIP_CTRL_EN_BIT]                 = en_q;
                cfg_rdata_o[XIP_CTRL_CPOL_BIT]               = cpol_q;
                cfg_rdata_o[XIP_CTRL_CPHA_BIT]               = cpha_q;
                cfg_rdata_o[XIP_CTRL_DIV_LSB +: XIP_DIV_W]   = div_q;
            end
            XIP_REG_CMD: cfg_rdata_o[XIP_OPC_W-1:0] = opcode_q;
            default: ;
        endcase
    end

    assign cfg_en_o     = en_q;
    assign cfg_cpol_o   = cpol_q;
    assign cfg_cpha_o   = cpha_q;
    assign cfg_div_o    = div_q;
    assign cfg_opcode_o = opcode_q;

endmodule

// ==== rtl/xip_prescaler.sv ====
// xip spi clock prescaler
// one-cycle enable pulse every 2^(div+1) clocks

`timescale 1ns/1ps

module xip_prescaler import xip_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 cfg_en_i,      // held in reset when low
    input  logic [XIP_DIV_W-1:0] cfg_div_i,     // power-of-two select
    output logic                 spi_clk_en_o   // single-cycle tick
);

    logic [XIP_PRESC_W-1:0] cnt_q;
    logic [XIP_PRESC_W-1:0] tc;

    // 2 << div wraps to zero at div 7, so minus one still gives 255
    assign tc = (XIP_PRESC_W'(2) << cfg_div_i) - 1'b1;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q        <= '0;
            spi_clk_en_o <= 1'b0;
        end else if (!cfg_en_i) begin                  // sync clear while disabled
            cnt_q        <= '0;
            spi_clk_en_o <= 1'b0;
        end else if (cnt_q >= tc) begin                // terminal count, also after div shrinks
            cnt_q        <= '0;
            spi_clk_en_o <= 1'b1;
        end else begin
            cnt_q        <= cnt_q + 1'b1;
            spi_clk_en_o <= 1'b0;
        end
    end

endmodule

// ==== rtl/xip_pkg.sv ====
// xip shared definitions
// bus and flash widths, read command layout, config register map

package xip_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int XIP_ADDR_W   = 24;                  // flash byte address
    localparam int XIP_DATA_W   = 32;                  // bus read word
    localparam int XIP_SREG_W   = 72;                  // engine shift reg, 9 bytes max
    localparam int XIP_NBYTES_W = 4;                   // byte count field
    localparam int XIP_OPC_W    = 8;                   // command opcode
    localparam int XIP_DIV_W    = 3;                   // prescaler select
    localparam int XIP_PRESC_W  = 1 << XIP_DIV_W;      // prescaler counter, 256 max

    // ------------------------------
    // read command
    // ------------------------------
    localparam logic [XIP_NBYTES_W-1:0] XIP_CMD_NBYTES = 4'd8;  // opcode, 3 addr, 4 data
    localparam int XIP_RESUME_BITS = 32;               // one word on a sequential resume
    localparam logic [XIP_OPC_W-1:0] XIP_OPC_READ_DEF = 8'h03;  // plain READ

    // ------------------------------
    // config register map
    // ------------------------------
    localparam logic [1:0] XIP_REG_CTRL = 2'd0;        // enable, mode, divider
    localparam logic [1:0] XIP_REG_CMD  = 2'd1;        // read opcode

    // control register fields
    localparam int XIP_CTRL_EN_BIT   = 0;
    localparam int XIP_CTRL_CPOL_BIT = 1;
    localparam int XIP_CTRL_CPHA_BIT = 2;
    localparam int XIP_CTRL_DIV_LSB  = 3;              // 3 bit field

endpackage
